// ==== Makefile ====
VERILATOR = verilator
LINT_FLAGS = --lint-only --timing
SIM_FLAGS = --binary --timing -j 0
TOP = core_tb
FILELIST = sim.f
OBJ_DIR = obj_dir
PASS_MSG = === PASS ===

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx -- "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== hdl/control_rom.sv ====
`timescale 1ns/1ps
`default_nettype none

module control_rom
	import lc3b_types::*;
(
	input lc3b_opcode opcode,
	input logic bit5,
	output lc3b_control_word ctrl
)
;

always_comb
begin
	// defaults: no load of any kind
	ctrl.aluop = alu_add;
	ctrl.alumux_sel = 1'b0;
	ctrl.regfilemux_sel = 1'b0;
	ctrl.lea_sel = 1'b0;
	ctrl.sr1_needed = 1'b0;
	ctrl.sr2_needed = 1'b0;
	ctrl.ld_reg = 1'b0;
	ctrl.ld_cc = 1'b0;

	case (opcode)
		op_add, op_and:
		begin
			ctrl.aluop = (opcode == op_add) ? alu_add : alu_and;
			ctrl.alumux_sel = bit5; // immediate form
			ctrl.sr1_needed = 1'b1;
			ctrl.sr2_needed = ~bit5;
			ctrl.ld_reg = 1'b1;
			ctrl.ld_cc = 1'b1;
		end

		op_not:
		begin
			ctrl.aluop = alu_not;
			ctrl.sr1_needed = 1'b1;
			ctrl.ld_reg = 1'b1;
			ctrl.ld_cc = 1'b1;
		end

		op_lea:
		begin
			ctrl.aluop = alu_pass;
			ctrl.lea_sel = 1'b1; // pc relative, no register sources
			ctrl.ld_reg = 1'b1;
			ctrl.ld_cc = 1'b1;
		end

		default: ;
	endcase
end

endmodule : control_rom

`default_nettype wire

// ==== hdl/decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode
	import lc3b_types::*;
(
	input logic clk,
	input logic rst,
	input fetch_pkt fetch,

	// dep check against execute
	input logic ex_valid,
	input logic ex_ld_reg,
	input lc3b_reg ex_drid,

	// writeback stage, also drives the regfile write
	input exec_pkt wb,

	output decode_pkt out,
	output logic dep_stall,
	output logic load_ex
);

lc3b_control_word ctrl;
lc3b_reg sr1_reg;
lc3b_reg sr2_reg;
lc3b_word sr1_data;
lc3b_word sr2_data;
logic sr1_hit;
logic sr2_hit;

// source matches a pending register write still in flight
function automatic logic pending_write(input lc3b_reg src, input logic ev, input logic eld,
	input lc3b_reg edr, input exec_pkt w);
	logic ex_match;
	logic wb_match;
	ex_match = ev && eld && (edr == src);
	wb_match = w.valid && w.ld_reg && (w.dr == src);
	return ex_match || wb_match;
endfunction

control_rom control_store
(
	.opcode(lc3b_opcode'(fetch.ir[15:12])),
	.bit5(fetch.ir[5]),
	.ctrl(ctrl)
);

assign sr1_reg = fetch.ir[8:6];
assign sr2_reg = ctrl.regfilemux_sel ? fetch.ir[11:9] : fetch.ir[2:0];

regfile regfile_int
(
	.clk(clk),
	.rst(rst),
	.load(wb.valid && wb.ld_reg),
	.in(wb.result),
	.src_a(sr1_reg),
	.src_b(sr2_reg),
	.dest(wb.dr),
	.reg_a(sr1_data),
	.reg_b(sr2_data)
);

always_comb
begin
	sr1_hit = ctrl.sr1_needed && pending_write(sr1_reg, ex_valid, ex_ld_reg, ex_drid, wb);
	sr2_hit = ctrl.sr2_needed && pending_write(sr2_reg, ex_valid, ex_ld_reg, ex_drid, wb);
	dep_stall = fetch.valid && (sr1_hit || sr2_hit);
	load_ex = fetch.valid && !dep_stall;
end

always_comb
begin
	out.valid = fetch.valid;
	out.ctrl = ctrl;
	out.npc = fetch.npc;
	out.ir = fetch.ir;
	out.sr1 = sr1_data;
	out.sr2 = sr2_data;
	out.dr = fetch.ir[11:9]; // every kept op writes ir[11:9]
end

endmodule : decode

`default_nettype wire

// ==== hdl/execute.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute
	import lc3b_types::*;
(
	input decode_pkt in,
	output exec_pkt out
);

lc3b_word imm5_sext;
lc3b_word offset9_addr;
lc3b_word operand_b;
lc3b_word alu_out;

assign imm5_sext = {{11{in.ir[4]}}, in.ir[4:0]};

// lea target, word offset scaled to bytes
assign offset9_addr = in.npc + {{6{in.ir[8]}}, in.ir[8:0], 1'b0};

always_comb
begin
	if (in.ctrl.lea_sel)
		operand_b = offset9_addr;
	else if (in.ctrl.alumux_sel)
		operand_b = imm5_sext;
	else
		operand_b = in.sr2;
end

always_comb
begin
	case (in.ctrl.aluop)
		alu_add: alu_out = in.sr1 + operand_b;
		alu_and: alu_out = in.sr1 & operand_b;
		alu_not: alu_out = ~in.sr1;
		default: alu_out = operand_b;
	endcase
end

always_comb
begin
	out.valid = in.valid;
	out.ld_reg = in.ctrl.ld_reg;
	out.ld_cc = in.ctrl.ld_cc;
	out.dr = in.dr;
	out.result = alu_out;
	out.nzp[2] = alu_out[15];
	out.nzp[1] = (alu_out == '0);
	out.nzp[0] = !alu_out[15] && (alu_out != '0);
end

endmodule : execute

`default_nettype wire

// ==== hdl/lc3b_config.svh ====
`ifndef LC3B_CONFIG_SVH
`define LC3B_CONFIG_SVH

// datapath and instruction width
`define LC3B_WORD_WIDTH 16

// general purpose registers r0..r7
`define LC3B_NUM_REGS 8

`endif

// ==== hdl/lc3b_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module lc3b_core
	import lc3b_types::*;
(
	input logic clk,
	input logic rst,
	input logic instr_valid,
	input lc3b_word instr,
	input lc3b_word instr_npc,
	output logic fetch_stall,
	output logic wb_valid,
	output lc3b_reg wb_dr,
	output lc3b_word wb_data,
	output lc3b_nzp wb_cc
);

fetch_pkt fetch_d;
fetch_pkt fetch_q;
decode_pkt dec_d;
decode_pkt dec_q;
exec_pkt exe_d;
exec_pkt exe_q;
logic dep_stall;
logic load_ex;
lc3b_nzp cc;

assign fetch_d = '{valid: instr_valid, npc: instr_npc, ir: instr};
assign fetch_stall = dep_stall;

// instruction latch, frozen while decode waits on a source
stage_reg #(.payload_t(fetch_pkt)) fetch_latch
(
	.clk(clk),
	.rst(rst),
	.load(!fetch_stall),
	.bubble(1'b0),
	.d(fetch_d),
	.q(fetch_q)
);

decode decode_i
(
	.clk(clk),
	.rst(rst),
	.fetch(fetch_q),
	.ex_valid(dec_q.valid),
	.ex_ld_reg(dec_q.ctrl.ld_reg),
	.ex_drid(dec_q.dr),
	.wb(exe_q),
	.out(dec_d),
	.dep_stall(dep_stall),
	.load_ex(load_ex)
);

stage_reg #(.payload_t(decode_pkt)) decode_ex_reg
(
	.clk(clk),
	.rst(rst),
	.load(1'b1),
	.bubble(!load_ex), // stalled or empty slot
	.d(dec_d),
	.q(dec_q)
);

execute execute_i
(
	.in(dec_q),
	.out(exe_d)
);

stage_reg #(.payload_t(exec_pkt)) ex_wb_reg
(
	.clk(clk),
	.rst(rst),
	.load(1'b1),
	.bubble(1'b0),
	.d(exe_d),
	.q(exe_q)
);

// writeback strobe lines up with the cc update
always_ff @(posedge clk)
begin
	if (rst)
	begin
		cc <= 3'b010;
		wb_valid <= 1'b0;
	end
	else
	begin
		if (exe_q.valid && exe_q.ld_cc)
			cc <= exe_q.nzp;
		wb_valid <= exe_q.valid && exe_q.ld_reg;
	end
	wb_dr <= exe_q.dr;
	wb_data <= exe_q.result;
end

assign wb_cc = cc;

endmodule : lc3b_core

`default_nettype wire

// ==== hdl/lc3b_types.sv ====
`default_nettype none

`include "lc3b_config.svh"

package lc3b_types;

typedef logic [`LC3B_WORD_WIDTH-1:0] lc3b_word;
typedef logic [2:0] lc3b_reg;
typedef logic [2:0] lc3b_nzp; // {n, z, p}

typedef enum logic [3:0] {
	op_br   = 4'b0000,
	op_add  = 4'b0001,
	op_ldb  = 4'b0010,
	op_stb  = 4'b0011,
	op_jsr  = 4'b0100,
	op_and  = 4'b0101,
	op_ldr  = 4'b0110,
	op_str  = 4'b0111,
	op_rti  = 4'b1000,
	op_not  = 4'b1001,
	op_ldi  = 4'b1010,
	op_sti  = 4'b1011,
	op_jmp  = 4'b1100,
	op_shf  = 4'b1101,
	op_lea  = 4'b1110,
	op_trap = 4'b1111
} lc3b_opcode;

typedef enum logic [1:0] {
	alu_add  = 2'b00,
	alu_and  = 2'b01,
	alu_not  = 2'b10,
	alu_pass = 2'b11 // passes operand b, used for lea
} alu_op;

typedef struct packed {
	alu_op aluop;
	logic alumux_sel;     // 1 = sext(imm5)
	logic regfilemux_sel; // 1 = sr2 from ir[11:9]
	logic lea_sel;
	logic sr1_needed;
	logic sr2_needed;
	logic ld_reg;
	logic ld_cc;
} lc3b_control_word;

typedef struct packed {
	logic valid;
	lc3b_word npc;
	lc3b_word ir;
} fetch_pkt;

typedef struct packed {
	logic valid;
	lc3b_control_word ctrl;
	lc3b_word npc;
	lc3b_word ir;
	lc3b_word sr1;
	lc3b_word sr2;
	lc3b_reg dr;
} decode_pkt;

typedef struct packed {
	logic valid;
	logic ld_reg;
	logic ld_cc;
	lc3b_reg dr;
	lc3b_word result;
	lc3b_nzp nzp;
} exec_pkt;

endpackage : lc3b_types

`default_nettype wire

// ==== hdl/regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lc3b_config.svh"

module regfile
	import lc3b_types::*;
(
	input logic clk,
	input logic rst,
	input logic load,
	input lc3b_word in,
	input lc3b_reg src_a,
	input lc3b_reg src_b,
	input lc3b_reg dest,
	output lc3b_word reg_a,
	output lc3b_word reg_b
);

logic [`LC3B_WORD_WIDTH-1:0] data [`LC3B_NUM_REGS];

always_ff @(posedge clk)
begin
	if (rst)
	begin
		for (int i = 0; i < `LC3B_NUM_REGS; i++)
			data[i] <= '0;
	end
	else if (load)
	begin
		data[dest] <= in;
	end
end

// no bypass, a same-cycle write shows up next cycle
assign reg_a = data[src_a];
assign reg_b = data[src_b];

endmodule : regfile

`default_nettype wire

// ==== hdl/stage_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

// generic pipeline boundary register, cleared to zero on reset or bubble
module stage_reg
#(
	parameter type payload_t = logic
)
(
	input logic clk,
	input logic rst,
	input logic load,
	input logic bubble,
	input payload_t d,
	output payload_t q
);

always_ff @(posedge clk)
begin
	if (rst || bubble)
	begin
		q <= '0; // all zero means valid low
	end
	else if (load)
	begin
		q <= d;
	end
end

endmodule : stage_reg

`default_nettype wire

// ==== sim.f ====
+incdir+hdl
hdl/lc3b_types.sv
hdl/stage_reg.sv
hdl/control_rom.sv
hdl/regfile.sv
hdl/decode.sv
hdl/execute.sv
hdl/lc3b_core.sv
verif/core_tb.sv

// ==== verif/core_stim.txt ====
// columns (hex): instr npc dr value nzp, where nzp is {n, z, p}
// dr f marks an op with no writeback, npc ffff ends the list
1225 3002 1 0005 1
143d 3004 2 fffd 4
562f 3006 3 0000 2
583f 3008 4 0000 2
1a42 300a 5 0002 1
5c42 300c 6 0005 1
9f7f 300e 7 fffd 4
13c6 3010 1 0002 1
127e 3012 1 0000 2
947f 3014 2 ffff 4
e604 3016 3 301e 1
e9ff 3018 4 3016 1
1ac4 301a 5 6034 1
0000 301c f 0000 0
5d78 301e 6 6030 1
1f86 3020 7 c060 4
51c2 3022 0 c060 4
903f 3024 0 3f9f 1
5220 3026 1 0000 2
1521 3028 2 3017 1
96bf 302a 3 cfe8 4
ee00 302c 7 302c 1
6000 302e f 0000 0
19c3 3030 4 0014 1
ffff ffff f 0000 0

// ==== verif/core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lc3b_config.svh"

module core_tb
	import lc3b_types::*;
();

localparam int MAX_TESTS = 64;
localparam int COLS = 5; // instr, npc, dr, value, nzp

typedef struct packed {
	logic [15:0] dr;
	logic [15:0] value;
	logic [15:0] nzp;
	int line_no;
} expect_t;

logic clk;
logic rst;
logic instr_valid;
lc3b_word instr;
lc3b_word instr_npc;
logic fetch_stall;
logic wb_valid;
lc3b_reg wb_dr;
lc3b_word wb_data;
lc3b_nzp wb_cc;

logic [`LC3B_WORD_WIDTH-1:0] stim_mem [COLS*MAX_TESTS];
expect_t expected_q[$];
int num_tests;
int expected_count;
int results_seen;
int error_count;
int cycle_limit;
int seed;
bit stim_loaded;

lc3b_core lc3b_core_i
(
	.clk(clk),
	.rst(rst),
	.instr_valid(instr_valid),
	.instr(instr),
	.instr_npc(instr_npc),
	.fetch_stall(fetch_stall),
	.wb_valid(wb_valid),
	.wb_dr(wb_dr),
	.wb_data(wb_data),
	.wb_cc(wb_cc)
);

initial
begin
	clk = 1'b0;
	forever #20 clk = ~clk;
end

task automatic compare_value(input string what, input logic [15:0] got,
	input logic [15:0] expected, inout bit ok);
	if (got !== expected)
	begin
		$display("Error: %0t ns: %s is %h, expected %h", $time, what, got, expected);
		error_count++;
		ok = 1'b0;
	end
endtask

// queue one expected result per line that writes a register
task automatic load_stim();
	expect_t e;
	num_tests = 0;
	expected_count = 0;
	$readmemh("verif/core_stim.txt", stim_mem);
	while (num_tests < MAX_TESTS && stim_mem[COLS*num_tests+1] != 16'hffff)
	begin
		if (stim_mem[COLS*num_tests+2] != 16'h000f)
		begin
			e.dr = stim_mem[COLS*num_tests+2];
			e.value = stim_mem[COLS*num_tests+3];
			e.nzp = stim_mem[COLS*num_tests+4];
			e.line_no = num_tests + 1;
			expected_q.push_back(e);
			expected_count++;
		end
		num_tests++;
	end
	if (num_tests == 0)
	begin
		$display("no stimulus lines were read from verif/core_stim.txt");
		error_count++;
	end
endtask

task automatic retire_result();
	expect_t e;
	bit ok;
	string verdict;
	ok = 1'b1;
	if (expected_q.size() == 0)
	begin
		$display("unexpected writeback to r%0d (value %h) at %0t ns", wb_dr, wb_data, $time);
		error_count++;
	end
	else
	begin
		e = expected_q.pop_front();
		compare_value($sformatf("test %0d dr", e.line_no), {13'b0, wb_dr}, e.dr, ok);
		compare_value($sformatf("test %0d data", e.line_no), wb_data, e.value, ok);
		compare_value($sformatf("test %0d nzp", e.line_no), {13'b0, wb_cc}, e.nzp, ok);
		results_seen++;
		if (ok)
			verdict = "ok";
		else
			verdict = "mismatch";
		$display("test %0d: r%0d <= %h, nzp %b, %s", e.line_no, wb_dr, wb_data, wb_cc,
			verdict);
	end
endtask

// present one line per accepted slot and hold it while the core stalls
task automatic run_stimulus();
	int idx;
	int gap_roll;
	bit stalled;
	bit holding;
	idx = 0;
	holding = 1'b0;
	while (idx < num_tests)
	begin
		if (!holding)
		begin
			gap_roll = $random(seed);
			if (gap_roll[1:0] == 2'b00)
				instr_valid = 1'b0; // idle slot
			else
			begin
				instr_valid = 1'b1;
				instr = stim_mem[COLS*idx];
				instr_npc = stim_mem[COLS*idx+1];
			end
		end
		@(negedge clk);
		stalled = fetch_stall; // settled mid cycle
		@(posedge clk);
		#2;
		if (instr_valid && !stalled)
			idx++;
		holding = stalled;
	end
	instr_valid = 1'b0;
endtask

always @(negedge clk)
begin
	if (!rst && wb_valid)
		retire_result();
end

initial
begin
	int cycle_count;
	cycle_count = 0;
	wait (stim_loaded);
	cycle_limit = num_tests * 8 + 16; // reset plus margin
	while (cycle_count < cycle_limit)
	begin
		@(posedge clk);
		cycle_count++;
	end
	$display("timeout: run did not finish in %0d cycles, %0d of %0d results seen",
		cycle_limit, results_seen, expected_count);
	$display("=== FAIL ===");
	$finish;
end

initial
begin
	bit reset_ok;
	rst = 1'b1;
	instr_valid = 1'b0;
	instr = '0;
	instr_npc = '0;
	seed = 32'h3fabee6c;
	error_count = 0;
	results_seen = 0;
	load_stim();
	stim_loaded = 1'b1;

	repeat (7) @(posedge clk);
	@(negedge clk);
	reset_ok = 1'b1;
	compare_value("fetch_stall in reset", {15'b0, fetch_stall}, 16'h0000, reset_ok);
	compare_value("wb_valid in reset", {15'b0, wb_valid}, 16'h0000, reset_ok);
	compare_value("wb_cc in reset", {13'b0, wb_cc}, 16'h0002, reset_ok);
	if (reset_ok)
		$display("test 0: reset state, ok");
	else
		$display("test 0: reset state, mismatch");
	@(posedge clk);
	#2;
	rst = 1'b0;

	run_stimulus();
	while (results_seen < expected_count)
		@(posedge clk);
	repeat (6) @(posedge clk); // let any stray strobe show up

	$display("%0d lines run, %0d results checked, %0d errors", num_tests, results_seen,
		error_count);
	if (error_count == 0)
		$display("=== PASS ===");
	else
		$display("=== FAIL ===");
	$finish;
end

endmodule : core_tb

`default_nettype wire
